// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Mdir obj_dir
TOP      = memfill_tb
FILELIST = memfill_top.f
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/memfill_defines.svh ====
`ifndef MEMFILL_DEFINES_SVH
`define MEMFILL_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// RAM geometry
////////////////////////////////////////////////////////////////////////////

// Word address bits
`define MEM_ADDR_WIDTH 5

// Bits per RAM word
`define MEM_DATA_WIDTH 32

// Words in the RAM, also the largest fill length
`define MEM_DEPTH 32

`endif

// ==== design/memfill_pkg.sv ====
`include "memfill_defines.svh"

package memfill_pkg;

	// Word address, wraps modulo the RAM depth
	typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;

	// One RAM word
	typedef logic [`MEM_DATA_WIDTH-1:0] data_t;

	// Fill length, 0 up to a full RAM of words
	typedef logic [$clog2(`MEM_DEPTH + 1)-1:0] count_t;

	// Fill engine states
	typedef enum logic [1:0]
	{
		ST_IDLE = 2'd0,
		ST_FILL = 2'd1,
		ST_DONE = 2'd2
	} fill_state_t;

endpackage

// ==== design/memfill_top.sv ====
`timescale 1ns/1ps
`include "memfill_defines.svh"

module memfill_top
(
	input  logic                clk,
	input  logic                reset,

	// Fill command
	input  logic                start_valid,
	output logic                start_ready,
	input  memfill_pkg::addr_t  base,
	input  memfill_pkg::data_t  fill,
	input  memfill_pkg::count_t count,

	// Completion
	output logic                done,
	output memfill_pkg::addr_t  done_base,

	// External read port
	input  logic                rd_valid,
	output logic                rd_ready,
	input  memfill_pkg::addr_t  rd_addr,
	output logic                rd_data_valid,
	output memfill_pkg::data_t  rd_data
);

	import memfill_pkg::*;

	memset_engine u_engine
	(
		.clk          (clk),
		.reset        (reset),
		.start_valid  (start_valid),
		.start_ready  (start_ready),
		.base         (base),
		.fill         (fill),
		.count        (count),
		.done         (done),
		.done_base    (done_base),
		.rd_valid     (rd_valid),
		.rd_ready     (rd_ready),
		.rd_addr      (rd_addr),
		.rd_data_valid(rd_data_valid),
		.rd_data      (rd_data)
	);

endmodule

// ==== design/memory_controller.sv ====
`timescale 1ns/1ps
`include "memfill_defines.svh"

module memory_controller
(
	input  logic               clk,
	input  logic               reset,

	input  logic               wr_valid,
	output logic               wr_ready,
	input  memfill_pkg::addr_t wr_addr,
	input  memfill_pkg::data_t wr_data,

	input  logic               rd_valid,
	output logic               rd_ready,
	input  memfill_pkg::addr_t rd_addr,
	output logic               rd_data_valid,
	output memfill_pkg::data_t rd_data
);

	import memfill_pkg::*;

	logic  rd_fire;
	logic  wr_fire;
	logic  rd_inflight;
	addr_t ram_addr;
	logic  ram_we;
	data_t ram_out;

	////////////////////////////////////////////////////////////////////////////
	// Port arbitration
	////////////////////////////////////////////////////////////////////////////

	// Reads always win, so a pending read holds off the writer
	assign rd_ready = 1'b1;
	assign wr_ready = !rd_valid;

	assign rd_fire = rd_valid && rd_ready;
	assign wr_fire = wr_valid && wr_ready;

	assign ram_addr = rd_fire ? rd_addr : wr_addr;
	assign ram_we   = wr_fire;

	single_port_ram
	#(
		.ADDR_WIDTH(`MEM_ADDR_WIDTH),
		.DATA_WIDTH(`MEM_DATA_WIDTH)
	)
	u_ram
	(
		.clk (clk),
		.addr(ram_addr),
		.we  (ram_we),
		.data(wr_data),
		.out (ram_out)
	);

	////////////////////////////////////////////////////////////////////////////
	// Read return pipeline
	////////////////////////////////////////////////////////////////////////////

	// Stage one is the RAM register, stage two is rd_data
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_inflight   <= 1'b0;
			rd_data_valid <= 1'b0;
		end
		else
		begin
			rd_inflight   <= rd_fire;
			rd_data_valid <= rd_inflight;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_inflight)
		begin
			rd_data <= ram_out;
		end
	end

	// Fixed two-cycle read latency, back-to-back reads included
	a_rd_latency: assert property (@(posedge clk) disable iff (reset)
		rd_fire |-> ##2 rd_data_valid)
		else $error("read data did not return two cycles after acceptance");

	// Engine write and outside read never share the RAM port
	a_no_collision: assert property (@(posedge clk) disable iff (reset)
		!(rd_fire && wr_fire))
		else $error("write and read committed in the same cycle");

endmodule

// ==== design/memset_engine.sv ====
`timescale 1ns/1ps
`include "memfill_defines.svh"

module memset_engine
(
	input  logic                clk,
	input  logic                reset,

	input  logic                start_valid,
	output logic                start_ready,
	input  memfill_pkg::addr_t  base,
	input  memfill_pkg::data_t  fill,
	input  memfill_pkg::count_t count,

	output logic                done,
	output memfill_pkg::addr_t  done_base,

	input  logic                rd_valid,
	output logic                rd_ready,
	input  memfill_pkg::addr_t  rd_addr,
	output logic                rd_data_valid,
	output memfill_pkg::data_t  rd_data
);

	import memfill_pkg::*;

	fill_state_t state;
	fill_state_t state_next;

	// Write path towards the controller
	logic  wr_valid;
	logic  wr_ready;
	addr_t wr_addr;
	data_t wr_data;

	logic   cmd_fire;
	logic   wr_fire;
	count_t remaining;
	addr_t  base_q;
	addr_t  addr_q;
	data_t  fill_q;

	assign start_ready = (state == ST_IDLE);
	assign cmd_fire    = start_valid && start_ready;
	assign wr_fire     = wr_valid && wr_ready;

	////////////////////////////////////////////////////////////////////////////
	// State machine
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_next = state;
		case (state)
			ST_IDLE:
			begin
				// An empty fill goes straight to done
				if (cmd_fire)
				begin
					state_next = (count == '0) ? ST_DONE : ST_FILL;
				end
			end
			ST_FILL:
			begin
				if (wr_fire && remaining == count_t'(1))
				begin
					state_next = ST_DONE;
				end
			end
			ST_DONE:
			begin
				state_next = ST_IDLE;
			end
			default:
			begin
				state_next = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state     <= ST_IDLE;
			wr_valid  <= 1'b0;
			done      <= 1'b0;
			remaining <= '0;
		end
		else
		begin
			state    <= state_next;
			wr_valid <= (state_next == ST_FILL);
			done     <= (state_next == ST_DONE);
			if (cmd_fire)
			begin
				remaining <= count;
			end
			else if (wr_fire)
			begin
				remaining <= remaining - 1'b1;
			end
		end
	end

	// Command payload and the running address, wraps at the RAM depth
	always_ff @(posedge clk)
	begin
		if (cmd_fire)
		begin
			base_q <= base;
			addr_q <= base;
			fill_q <= fill;
		end
		else if (wr_fire)
		begin
			addr_q <= addr_q + 1'b1;
		end
	end

	assign wr_addr   = addr_q;
	assign wr_data   = fill_q;
	assign done_base = base_q;

	memory_controller u_ctrl
	(
		.clk          (clk),
		.reset        (reset),
		.wr_valid     (wr_valid),
		.wr_ready     (wr_ready),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.rd_valid     (rd_valid),
		.rd_ready     (rd_ready),
		.rd_addr      (rd_addr),
		.rd_data_valid(rd_data_valid),
		.rd_data      (rd_data)
	);

	a_wr_in_fill: assert property (@(posedge clk) disable iff (reset)
		wr_valid |-> state == ST_FILL)
		else $error("write request outside the fill state");

	a_done_pulse: assert property (@(posedge clk) disable iff (reset)
		done |=> !done)
		else $error("done held for more than one cycle");

endmodule

// ==== design/single_port_ram.sv ====
`timescale 1ns/1ps
`include "memfill_defines.svh"

module single_port_ram
#(
	parameter int ADDR_WIDTH = `MEM_ADDR_WIDTH,
	parameter int DATA_WIDTH = `MEM_DATA_WIDTH
)
(
	input  logic                  clk,
	input  logic [ADDR_WIDTH-1:0] addr,
	input  logic                  we,
	input  logic [DATA_WIDTH-1:0] data,
	output logic [DATA_WIDTH-1:0] out
);

	logic [DATA_WIDTH-1:0] mem [0:(1 << ADDR_WIDTH)-1];

	// Read-first: on a write the old word comes out
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[addr] <= data;
		end
		out <= mem[addr];
	end

endmodule

// ==== dv/memfill_checker.sv ====
`timescale 1ns/1ps
`include "memfill_defines.svh"

module memfill_checker
(
	input  logic                clk,
	input  logic                reset,
	input  logic                start_valid,
	input  logic                start_ready,
	input  memfill_pkg::addr_t  base,
	input  memfill_pkg::data_t  fill,
	input  memfill_pkg::count_t count,
	input  logic                done,
	input  memfill_pkg::addr_t  done_base,
	input  logic                rd_valid,
	input  logic                rd_ready,
	input  memfill_pkg::addr_t  rd_addr,
	input  logic                rd_data_valid,
	input  memfill_pkg::data_t  rd_data,
	output int                  errors
);

	import memfill_pkg::*;

	// Whole RAM image, one word per address
	typedef logic [`MEM_DEPTH-1:0][`MEM_DATA_WIDTH-1:0] image_t;

	image_t model;
	addr_t  rd_addr_q[$];
	data_t  rd_exp_q[$];
	int     rd_cycle_q[$];
	int     cycle;
	int     writes_left;
	logic   fill_active;
	logic   done_due;
	logic   check_reset_values;
	addr_t  exp_base;

	// Reference fill: n words from b, addresses wrap at the RAM depth
	function automatic image_t apply_fill(image_t img, addr_t b, data_t v, count_t n);
		addr_t a;
		a = b;
		for (int i = 0; i < int'(n); i++)
		begin
			img[a] = v;
			a = a + 5'd1;
		end
		return img;
	endfunction

	initial
	begin
		model              = 'x;
		errors             = 0;
		cycle              = 0;
		writes_left        = 0;
		fill_active        = 1'b0;
		done_due           = 1'b0;
		check_reset_values = 1'b0;
		exp_base           = '0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare on every rising edge, using the values held before the edge
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		cycle++;
		if (reset)
		begin
			check_reset_values = 1'b1;
			fill_active        = 1'b0;
			done_due           = 1'b0;
			rd_addr_q.delete();
			rd_exp_q.delete();
			rd_cycle_q.delete();
		end
		else
		begin
			if (check_reset_values)
			begin
				if (start_ready !== 1'b1)
				begin
					$display("mismatch start_ready after reset: got %h expected 1", start_ready);
					errors++;
				end
				if (done !== 1'b0)
				begin
					$display("mismatch done after reset: got %h expected 0", done);
					errors++;
				end
				if (rd_data_valid !== 1'b0)
				begin
					$display("mismatch rd_data_valid after reset: got %h expected 0",
						rd_data_valid);
					errors++;
				end
				check_reset_values = 1'b0;
			end

			// The read port never pushes back
			if (rd_ready !== 1'b1)
			begin
				$display("mismatch rd_ready: got %h expected 1", rd_ready);
				errors++;
			end

			// Commands are taken only between fills, done cycle included
			if (start_ready !== !fill_active)
			begin
				$display("mismatch start_ready: got %h expected %h",
					start_ready, !fill_active);
				errors++;
			end

			// Completion comes one cycle after the last accepted write
			if (done)
			begin
				if (!done_due)
				begin
					$display("done pulsed at cycle %0d while no completion was due", cycle);
					errors++;
				end
				else if (done_base !== exp_base)
				begin
					$display("mismatch done_base: got %h expected %h", done_base, exp_base);
					errors++;
				end
				done_due    = 1'b0;
				fill_active = 1'b0;
			end
			else if (done_due)
			begin
				$display("done pulse missing at cycle %0d for the fill at base %h",
					cycle, exp_base);
				errors++;
				done_due    = 1'b0;
				fill_active = 1'b0;
			end

			// Any pending read holds off the engine's write this cycle
			if (fill_active && writes_left > 0 && !rd_valid)
			begin
				writes_left--;
				if (writes_left == 0)
				begin
					done_due = 1'b1;
				end
			end

			if (start_valid && start_ready)
			begin
				model       = apply_fill(model, base, fill, count);
				exp_base    = base;
				fill_active = 1'b1;
				writes_left = int'(count);
				done_due    = (count == '0);
			end

			if (rd_data_valid)
			begin
				if (rd_cycle_q.size() == 0)
				begin
					$display("rd_data_valid at cycle %0d with no read outstanding", cycle);
					errors++;
				end
				else
				begin
					if (rd_cycle_q[0] != cycle - 2)
					begin
						$display("read accepted at cycle %0d returned at cycle %0d",
							rd_cycle_q[0], cycle);
						errors++;
					end
					if (rd_data !== rd_exp_q[0])
					begin
						$display("mismatch rd_data at address %h: got %h expected %h",
							rd_addr_q[0], rd_data, rd_exp_q[0]);
						errors++;
					end
					void'(rd_addr_q.pop_front());
					void'(rd_exp_q.pop_front());
					void'(rd_cycle_q.pop_front());
				end
			end
			if (rd_cycle_q.size() > 0 && rd_cycle_q[0] < cycle - 2)
			begin
				$display("read data for address %h never came back", rd_addr_q[0]);
				errors++;
				void'(rd_addr_q.pop_front());
				void'(rd_exp_q.pop_front());
				void'(rd_cycle_q.pop_front());
			end

			// Expected word is the model content when the read is accepted
			if (rd_valid && rd_ready)
			begin
				rd_addr_q.push_back(rd_addr);
				rd_exp_q.push_back(model[rd_addr]);
				rd_cycle_q.push_back(cycle);
			end
		end
	end

endmodule

// ==== dv/memfill_tb.sv ====
`timescale 1ns/1ps
`include "memfill_defines.svh"

module memfill_tb;

	import memfill_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int RANDOM_FILLS = 6;
	// Initial clear, random fills, three corner fills, one fill under read traffic
	localparam int NUM_CMDS     = RANDOM_FILLS + 5;
	localparam int NUM_SWEEPS   = NUM_CMDS + 1;
	localparam int WATCHDOG_CYCLES = NUM_CMDS * 40 + NUM_SWEEPS * (`MEM_DEPTH + 4) + 50;

	logic   clk;
	logic   reset;
	logic   start_valid;
	logic   start_ready;
	addr_t  base;
	data_t  fill;
	count_t count;
	logic   done;
	addr_t  done_base;
	logic   rd_valid;
	logic   rd_ready;
	addr_t  rd_addr;
	logic   rd_data_valid;
	data_t  rd_data;

	logic [31:0] rng_state;
	int          checker_errors;
	int          stim_errors;
	addr_t       fill_base;

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] rand32();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus tasks, each starts and ends just after a rising edge
	////////////////////////////////////////////////////////////////////////////

	task automatic issue_fill(input addr_t b, input data_t v, input count_t n);
		start_valid <= 1'b1;
		base        <= b;
		fill        <= v;
		count       <= n;
		@(posedge clk);
		while (!start_ready)
		begin
			@(posedge clk);
		end
		start_valid <= 1'b0;
	endtask

	task automatic wait_done();
		int waited;
		waited = 0;
		@(posedge clk);
		while (!done && waited < 100)
		begin
			@(posedge clk);
			waited++;
		end
		if (!done)
		begin
			$display("done pulse did not arrive within 100 cycles of a fill command");
			stim_errors++;
		end
	endtask

	task automatic run_fill(input addr_t b, input data_t v, input count_t n);
		issue_fill(b, v, n);
		wait_done();
	endtask

	task automatic read_sweep();
		for (int a = 0; a < `MEM_DEPTH; a++)
		begin
			rd_valid <= 1'b1;
			rd_addr  <= addr_t'(a);
			@(posedge clk);
		end
		rd_valid <= 1'b0;
		repeat (3) @(posedge clk);
	endtask

	task automatic read_burst(input int n);
		for (int i = 0; i < n; i++)
		begin
			rd_valid <= 1'b1;
			rd_addr  <= addr_t'(rand32() >> 11);
			@(posedge clk);
		end
		rd_valid <= 1'b0;
		repeat (3) @(posedge clk);
	endtask

	// Reads land in the half of the RAM that the running fill does not touch
	task automatic reads_outside_fill(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			rd_valid <= (i % 3 != 2);
			rd_addr  <= fill_base + 5'd16 + addr_t'(rand32() % 16);
			@(posedge clk);
		end
		rd_valid <= 1'b0;
	endtask

	initial
	begin
		reset       = 1'b1;
		start_valid = 1'b0;
		base        = '0;
		fill        = '0;
		count       = '0;
		rd_valid    = 1'b0;
		rd_addr     = '0;
		rng_state   = 32'h200215e5;
		stim_errors = 0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		repeat (2) @(posedge clk);

		// Known contents everywhere before any partial fill
		run_fill(5'd0, rand32(), 6'd32);
		read_sweep();
		for (int i = 0; i < RANDOM_FILLS; i++)
		begin
			run_fill(addr_t'(rand32() >> 8), rand32(), count_t'((rand32() >> 16) % 33));
			read_sweep();
		end

		run_fill(5'd28, rand32(), 6'd10);
		read_sweep();
		run_fill(5'd17, rand32(), 6'd32);
		read_sweep();
		run_fill(5'd9, rand32(), 6'd0);
		read_sweep();
		read_burst(16);

		fill_base = addr_t'(rand32() >> 8);
		issue_fill(fill_base, rand32(), 6'd16);
		reads_outside_fill(8);
		wait_done();
		read_sweep();

		$display("%0d errors: %0d from the checker, %0d from the stimulus",
			checker_errors + stim_errors, checker_errors, stim_errors);
		if (checker_errors + stim_errors == 0)
		begin
			$display("TESTBENCH PASSED");
		end
		else
		begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles before the tests finished",
			WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	memfill_top dut
	(
		.clk          (clk),
		.reset        (reset),
		.start_valid  (start_valid),
		.start_ready  (start_ready),
		.base         (base),
		.fill         (fill),
		.count        (count),
		.done         (done),
		.done_base    (done_base),
		.rd_valid     (rd_valid),
		.rd_ready     (rd_ready),
		.rd_addr      (rd_addr),
		.rd_data_valid(rd_data_valid),
		.rd_data      (rd_data)
	);

	memfill_checker u_checker
	(
		.clk          (clk),
		.reset        (reset),
		.start_valid  (start_valid),
		.start_ready  (start_ready),
		.base         (base),
		.fill         (fill),
		.count        (count),
		.done         (done),
		.done_base    (done_base),
		.rd_valid     (rd_valid),
		.rd_ready     (rd_ready),
		.rd_addr      (rd_addr),
		.rd_data_valid(rd_data_valid),
		.rd_data      (rd_data),
		.errors       (checker_errors)
	);

endmodule

// ==== memfill_top.f ====
+incdir+design
design/memfill_pkg.sv
design/single_port_ram.sv
design/memory_controller.sv
design/memset_engine.sv
design/memfill_top.sv
dv/memfill_checker.sv
dv/memfill_tb.sv
